// ==== ilk_pkg.sv ====
/*
 * shared constants for the interlaken transmit path
 * one lane group, 64-bit words, avalon beats of two words
 * crc24 and calendar fields of the control words are always zero
 * no scrambling, framing or meta frame support
 */

`default_nettype none

package ilk_pkg;

   // interlaken word and avalon beat geometry
   localparam int WORD_W    = 64;
   localparam int AVL_WORDS = 2;
   localparam int BEAT_W    = WORD_W * AVL_WORDS;

   // word count per beat, 0 to 2
   localparam int NUM_VALID_W = 2;
   localparam logic [NUM_VALID_W-1:0] NUM_ZERO = 2'd0;
   localparam logic [NUM_VALID_W-1:0] NUM_ONE  = 2'd1;
   localparam logic [NUM_VALID_W-1:0] NUM_TWO  = 2'd2;

   // avalon empty counts empty bytes over the whole beat
   localparam int EMPTY_W = 4;
   // bytes in one word, as an empty value
   localparam logic [EMPTY_W-1:0] WORD_BYTES = 4'd8;

   localparam int CHAN_W = 8;

   // end of packet code
   localparam int EOPBITS_W = 4;
   localparam logic [EOPBITS_W-1:0] EOP_NONE = 4'b0000;
   localparam logic [EOPBITS_W-1:0] EOP_ERR  = 4'b0001;
   // set on a clean eop, low bits then give valid bytes mod 8
   localparam int EOP_VALID_BIT = 3;

   // control word fields
   // bit 63 marks a control word
   localparam int CW_CTRL_BIT = 63;
   // 1 for burst control, 0 for idle control
   localparam int CW_TYPE_BIT = 62;
   localparam int CW_SOP_BIT  = 61;
   localparam int CW_EOP_HI   = 60;
   localparam int CW_EOP_LO   = 57;
   localparam int CW_CHAN_HI  = 39;
   localparam int CW_CHAN_LO  = 32;

   // everything else in a control word stays zero
   // this covers crc24 (23:0) and the calendar bits

endpackage

`default_nettype wire

// ==== avl_to_ilk_adapter.sv ====
/*
 * avalon streaming beat to interlaken beat form, purely combinational
 * empty counts bytes from the low end, word 0 is the upper 64 bits
 * a non-eop beat with an empty other than 0 or 8 yields zero words
 * ready goes straight through, no buffering
 */

`timescale 1ns/1ps
`default_nettype none

module avl_to_ilk_adapter (
   // avalon side
   input  wire  [ilk_pkg::BEAT_W-1:0]      avl_data,
   input  wire                             avl_sop,
   input  wire                             avl_eop,
   input  wire  [ilk_pkg::EMPTY_W-1:0]     avl_empty,
   input  wire                             avl_error,
   input  wire                             avl_valid,
   output logic                            avl_ready,
   // interlaken beat side
   output logic [ilk_pkg::BEAT_W-1:0]      beat_data,
   output logic [ilk_pkg::NUM_VALID_W-1:0] beat_num_valid,
   output logic                            beat_sop,
   output logic [ilk_pkg::EOPBITS_W-1:0]   beat_eopbits,
   output logic                            beat_valid,
   input  wire                             beat_ready
);

   // valid bytes in the last word, only the low bits matter
   logic [ilk_pkg::EMPTY_W-1:0] valid_bytes;
   logic                        eop_err;

   assign valid_bytes = ilk_pkg::WORD_BYTES - avl_empty;
   assign eop_err     = avl_valid & avl_eop & avl_error;

   // word count
   always_comb begin
      beat_num_valid = ilk_pkg::NUM_ZERO;
      if (avl_valid && !avl_eop) begin
         // mid-packet beats must be full or exactly one word
         if (avl_empty == '0) begin
            beat_num_valid = ilk_pkg::NUM_TWO;
         end else if (avl_empty == ilk_pkg::WORD_BYTES) begin
            beat_num_valid = ilk_pkg::NUM_ONE;
         end else begin
            // illegal empty, nothing is taken from the beat
            beat_num_valid = ilk_pkg::NUM_ZERO;
         end
      end else if (avl_valid) begin
         // last beat, second word only when empty leaves bytes in it
         if (avl_empty < ilk_pkg::WORD_BYTES) begin
            beat_num_valid = ilk_pkg::NUM_TWO;
         end else begin
            beat_num_valid = ilk_pkg::NUM_ONE;
         end
      end
   end

   // end of packet code
   always_comb begin
      beat_eopbits = ilk_pkg::EOP_NONE;
      if (eop_err) begin
         beat_eopbits = ilk_pkg::EOP_ERR;
      end else if (avl_valid && avl_eop) begin
         // 8 minus empty, taken mod 8, so a full word reads as 000
         beat_eopbits[ilk_pkg::EOP_VALID_BIT] = 1'b1;
         beat_eopbits[ilk_pkg::EOP_VALID_BIT-1:0] =
            valid_bytes[ilk_pkg::EOP_VALID_BIT-1:0];
      end
   end

   // payload and handshake go through untouched
   assign beat_data  = avl_data;
   assign beat_sop   = avl_sop;
   assign beat_valid = avl_valid;
   assign avl_ready  = beat_ready;

endmodule

`default_nettype wire

// ==== ilk_word_serializer.sv ====
/*
 * splits a two-word beat into single 64-bit words
 * one beat is held at a time, the next is taken with the last word
 * sop rides on the first word, the eop code on the last one
 * beats with a word count of zero are accepted and dropped
 */

`timescale 1ns/1ps
`default_nettype none

module ilk_word_serializer (
   input  wire                             clk,
   input  wire                             arst_n,
   // beat input
   input  wire  [ilk_pkg::BEAT_W-1:0]      beat_data,
   input  wire  [ilk_pkg::NUM_VALID_W-1:0] beat_num_valid,
   input  wire                             beat_sop,
   input  wire  [ilk_pkg::EOPBITS_W-1:0]   beat_eopbits,
   input  wire                             beat_valid,
   output logic                            beat_ready,
   // channel of the packet, sampled with its sop beat
   input  wire  [ilk_pkg::CHAN_W-1:0]      avl_channel,
   // word output
   output logic [ilk_pkg::WORD_W-1:0]      word_data,
   output logic                            word_sop,
   output logic [ilk_pkg::EOPBITS_W-1:0]   word_eopbits,
   output logic [ilk_pkg::CHAN_W-1:0]      word_channel,
   output logic                            word_valid,
   input  wire                             word_ready
);

   // control state
   logic                            full_q;
   logic                            idx_q;
   // held beat
   logic [ilk_pkg::BEAT_W-1:0]      data_q;
   logic [ilk_pkg::NUM_VALID_W-1:0] num_q;
   logic                            sop_q;
   logic [ilk_pkg::EOPBITS_W-1:0]   eop_q;
   logic [ilk_pkg::CHAN_W-1:0]      chan_q;

   logic last_word;
   logic word_take;
   logic beat_take;
   logic beat_load;

   // a held beat always has one or two words
   assign last_word = idx_q | (num_q == ilk_pkg::NUM_ONE);
   assign word_take = full_q & word_ready;

   // free, or the last word leaves on this edge
   assign beat_ready = ~full_q | (word_take & last_word);
   assign beat_take  = beat_valid & beat_ready;
   // empty beats are swallowed here
   assign beat_load  = beat_take & (beat_num_valid != ilk_pkg::NUM_ZERO);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         full_q <= 1'b0;
         idx_q  <= 1'b0;
      end else begin
         if (beat_load) begin
            full_q <= 1'b1;
            idx_q  <= 1'b0;
         end else if (word_take) begin
            if (last_word) begin
               full_q <= 1'b0;
               idx_q  <= 1'b0;
            end else begin
               idx_q <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (beat_load) begin
         data_q <= beat_data;
         num_q  <= beat_num_valid;
         sop_q  <= beat_sop;
         eop_q  <= beat_eopbits;
      end
      // channel stays for the rest of the packet
      if (beat_take && beat_sop) begin
         chan_q <= avl_channel;
      end
   end

   // word 0 is the upper half of the beat
   assign word_data = idx_q ? data_q[ilk_pkg::WORD_W-1:0]
                            : data_q[ilk_pkg::BEAT_W-1:ilk_pkg::WORD_W];

   assign word_sop     = sop_q & ~idx_q;
   assign word_eopbits = last_word ? eop_q : ilk_pkg::EOP_NONE;
   assign word_channel = chan_q;
   assign word_valid   = full_q;

endmodule

`default_nettype wire

// ==== ilk_ctrl_word_inserter.sv ====
/*
 * puts a burst control word before each packet and an idle control
 * word with the eop code after it, data words pass with tx_ctrl low
 * a packet is one burst of any length, crc24 is sent as zero
 * output is one register stage with a valid/ready handshake
 */

`timescale 1ns/1ps
`default_nettype none

module ilk_ctrl_word_inserter (
   input  wire                           clk,
   input  wire                           arst_n,
   // word input
   input  wire  [ilk_pkg::WORD_W-1:0]    word_data,
   input  wire                           word_sop,
   input  wire  [ilk_pkg::EOPBITS_W-1:0] word_eopbits,
   input  wire  [ilk_pkg::CHAN_W-1:0]    word_channel,
   input  wire                           word_valid,
   output logic                          word_ready,
   // transmit output
   output logic [ilk_pkg::WORD_W-1:0]    tx_data,
   output logic                          tx_ctrl,
   output logic                          tx_valid,
   input  wire                           tx_ready
);

   // st_burst means the burst word went out and the sop word waits
   // st_idle means the idle word after a packet still has to go out
   typedef enum logic [1:0] {
      ST_DATA,
      ST_BURST,
      ST_IDLE
   } state_t;

   state_t state_q;
   state_t state_d;

   logic                          out_free;
   logic                          load;
   logic                          load_ctrl;
   logic [ilk_pkg::WORD_W-1:0]    load_data;
   logic                          eop_hold;
   logic [ilk_pkg::EOPBITS_W-1:0] eop_q;
   logic [ilk_pkg::WORD_W-1:0]    burst_cw;
   logic [ilk_pkg::WORD_W-1:0]    idle_cw;

   // output register can take a new word
   assign out_free = ~tx_valid | tx_ready;

   // control word images
   always_comb begin
      burst_cw = '0;
      burst_cw[ilk_pkg::CW_CTRL_BIT] = 1'b1;
      burst_cw[ilk_pkg::CW_TYPE_BIT] = 1'b1;
      burst_cw[ilk_pkg::CW_SOP_BIT]  = 1'b1;
      burst_cw[ilk_pkg::CW_CHAN_HI:ilk_pkg::CW_CHAN_LO] = word_channel;

      // idle type is bit 62 left at zero
      idle_cw = '0;
      idle_cw[ilk_pkg::CW_CTRL_BIT] = 1'b1;
      idle_cw[ilk_pkg::CW_EOP_HI:ilk_pkg::CW_EOP_LO] = eop_q;
   end

   // sequencing
   always_comb begin
      state_d    = state_q;
      word_ready = 1'b0;
      load       = 1'b0;
      load_ctrl  = 1'b0;
      load_data  = word_data;
      eop_hold   = 1'b0;
      case (state_q)
         ST_DATA: begin
            if (word_valid && out_free) begin
               if (word_sop) begin
                  // sop word is held back behind its burst word
                  load      = 1'b1;
                  load_ctrl = 1'b1;
                  load_data = burst_cw;
                  state_d   = ST_BURST;
               end else begin
                  word_ready = 1'b1;
                  load       = 1'b1;
                  if (word_eopbits != ilk_pkg::EOP_NONE) begin
                     eop_hold = 1'b1;
                     state_d  = ST_IDLE;
                  end
               end
            end
         end
         ST_BURST: begin
            // pass the waiting sop word
            word_ready = out_free;
            if (word_valid && out_free) begin
               load = 1'b1;
               if (word_eopbits != ilk_pkg::EOP_NONE) begin
                  eop_hold = 1'b1;
                  state_d  = ST_IDLE;
               end else begin
                  state_d = ST_DATA;
               end
            end
         end
         ST_IDLE: begin
            // no input taken until the idle word is out
            if (out_free) begin
               load      = 1'b1;
               load_ctrl = 1'b1;
               load_data = idle_cw;
               state_d   = ST_DATA;
            end
         end
         default: begin
            state_d = ST_DATA;
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q  <= ST_DATA;
         tx_valid <= 1'b0;
      end else begin
         state_q <= state_d;
         if (out_free) begin
            tx_valid <= load;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         tx_data <= load_data;
         tx_ctrl <= load_ctrl;
      end
      // code of the packet just closed
      if (eop_hold) begin
         eop_q <= word_eopbits;
      end
   end

endmodule

`default_nettype wire

// ==== ilk_tx_subsystem.sv ====
/*
 * interlaken transmit path for one lane group
 * avalon beats in, 64-bit words with a control flag out
 * latency varies with packet shape and back-pressure
 */

`timescale 1ns/1ps
`default_nettype none

module ilk_tx_subsystem (
   input  wire                           clk,
   input  wire                           arst_n,
   // avalon streaming input
   input  wire  [ilk_pkg::BEAT_W-1:0]    avl_data,
   input  wire                           avl_sop,
   input  wire                           avl_eop,
   input  wire  [ilk_pkg::EMPTY_W-1:0]   avl_empty,
   input  wire                           avl_error,
   input  wire                           avl_valid,
   input  wire  [ilk_pkg::CHAN_W-1:0]    avl_channel,
   output logic                          avl_ready,
   // word stream output
   output logic [ilk_pkg::WORD_W-1:0]    tx_data,
   output logic                          tx_ctrl,
   output logic                          tx_valid,
   input  wire                           tx_ready
);

   // adapter to serializer
   logic [ilk_pkg::BEAT_W-1:0]      beat_data;
   logic [ilk_pkg::NUM_VALID_W-1:0] beat_num_valid;
   logic                            beat_sop;
   logic [ilk_pkg::EOPBITS_W-1:0]   beat_eopbits;
   logic                            beat_valid;
   logic                            beat_ready;

   // serializer to inserter
   logic [ilk_pkg::WORD_W-1:0]      word_data;
   logic                            word_sop;
   logic [ilk_pkg::EOPBITS_W-1:0]   word_eopbits;
   logic [ilk_pkg::CHAN_W-1:0]      word_channel;
   logic                            word_valid;
   logic                            word_ready;

   avl_to_ilk_adapter i_avl_to_ilk_adapter (
      .avl_data       (avl_data),
      .avl_sop        (avl_sop),
      .avl_eop        (avl_eop),
      .avl_empty      (avl_empty),
      .avl_error      (avl_error),
      .avl_valid      (avl_valid),
      .avl_ready      (avl_ready),
      .beat_data      (beat_data),
      .beat_num_valid (beat_num_valid),
      .beat_sop       (beat_sop),
      .beat_eopbits   (beat_eopbits),
      .beat_valid     (beat_valid),
      .beat_ready     (beat_ready)
   );

   // channel bypasses the adapter, sampled on the sop beat
   ilk_word_serializer i_ilk_word_serializer (
      .clk            (clk),
      .arst_n         (arst_n),
      .beat_data      (beat_data),
      .beat_num_valid (beat_num_valid),
      .beat_sop       (beat_sop),
      .beat_eopbits   (beat_eopbits),
      .beat_valid     (beat_valid),
      .beat_ready     (beat_ready),
      .avl_channel    (avl_channel),
      .word_data      (word_data),
      .word_sop       (word_sop),
      .word_eopbits   (word_eopbits),
      .word_channel   (word_channel),
      .word_valid     (word_valid),
      .word_ready     (word_ready)
   );

   ilk_ctrl_word_inserter i_ilk_ctrl_word_inserter (
      .clk            (clk),
      .arst_n         (arst_n),
      .word_data      (word_data),
      .word_sop       (word_sop),
      .word_eopbits   (word_eopbits),
      .word_channel   (word_channel),
      .word_valid     (word_valid),
      .word_ready     (word_ready),
      .tx_data        (tx_data),
      .tx_ctrl        (tx_ctrl),
      .tx_valid       (tx_valid),
      .tx_ready       (tx_ready)
   );

endmodule

`default_nettype wire

// ==== tb_ilk_tx.sv ====
/*
 * random packet testbench for the interlaken transmit path
 * inputs change on the rising edge and beats and outputs are sampled on the falling edge
 * middle beats get empty 0, 8 or an odd illegal value
 * sop beats stay full unless they also end the packet
 * tx_ready is low about one cycle in three
 */

`timescale 1ns/1ps
`default_nettype none

module tb_ilk_tx;

   localparam logic [31:0] SEED = 32'hf432_652c;
   localparam int NUM_PKTS    = 300;
   localparam int BEAT_LIMIT  = 200;
   localparam int DRAIN_LIMIT = 2000;

   logic                            clk;
   logic                            arst_n;
   logic [ilk_pkg::BEAT_W-1:0]      avl_data;
   logic                            avl_sop;
   logic                            avl_eop;
   logic [ilk_pkg::EMPTY_W-1:0]     avl_empty;
   logic                            avl_error;
   logic                            avl_valid;
   logic [ilk_pkg::CHAN_W-1:0]      avl_channel;
   logic                            avl_ready;
   logic [ilk_pkg::WORD_W-1:0]      tx_data;
   logic                            tx_ctrl;
   logic                            tx_valid;
   logic                            tx_ready;

   // expected words with the control flag in bit 64
   logic [ilk_pkg::WORD_W:0] exp_q[$];
   logic [31:0] stim_state;
   logic [31:0] rdy_state;
   int          mismatch_count;
   int          other_count;
   int          post_reset_cycles;
   logic        timed_out;

   ilk_tx_subsystem i_ilk_tx_subsystem (
      .clk         (clk),
      .arst_n      (arst_n),
      .avl_data    (avl_data),
      .avl_sop     (avl_sop),
      .avl_eop     (avl_eop),
      .avl_empty   (avl_empty),
      .avl_error   (avl_error),
      .avl_valid   (avl_valid),
      .avl_channel (avl_channel),
      .avl_ready   (avl_ready),
      .tx_data     (tx_data),
      .tx_ctrl     (tx_ctrl),
      .tx_valid    (tx_valid),
      .tx_ready    (tx_ready)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // stimulus stream for the packet process
   function automatic logic [31:0] next_rand();
      stim_state = lcg_next(stim_state);
      return stim_state;
   endfunction

   // back-pressure from a second generator state
   initial begin
      forever begin
         @(posedge clk);
         rdy_state = lcg_next(rdy_state);
         tx_ready <= (rdy_state[31:24] % 3) != 0;
      end
   end

   // expected output for one accepted avalon beat
   task automatic predict_beat();
      logic [1:0]                   num;
      logic [3:0]                   vb;
      logic [ilk_pkg::EOPBITS_W-1:0] code;
      logic [ilk_pkg::WORD_W-1:0]   cw;
      if (!avl_eop) begin
         num = (avl_empty == 4'd0) ? 2'd2 : ((avl_empty == 4'd8) ? 2'd1 : 2'd0);
      end else begin
         num = (avl_empty < 4'd8) ? 2'd2 : 2'd1;
      end
      if (avl_sop) begin
         // burst control word with the channel
         cw = '0;
         cw[ilk_pkg::CW_CTRL_BIT] = 1'b1;
         cw[ilk_pkg::CW_TYPE_BIT] = 1'b1;
         cw[ilk_pkg::CW_SOP_BIT]  = 1'b1;
         cw[ilk_pkg::CW_CHAN_HI:ilk_pkg::CW_CHAN_LO] = avl_channel;
         exp_q.push_back({1'b1, cw});
      end
      // upper half leaves first
      if (num >= 2'd1) exp_q.push_back({1'b0, avl_data[127:64]});
      if (num == 2'd2) exp_q.push_back({1'b0, avl_data[63:0]});
      if (avl_eop) begin
         vb   = 4'd8 - avl_empty;
         code = avl_error ? ilk_pkg::EOP_ERR : {1'b1, vb[2:0]};
         cw   = '0;
         cw[ilk_pkg::CW_CTRL_BIT] = 1'b1;
         cw[ilk_pkg::CW_EOP_HI:ilk_pkg::CW_EOP_LO] = code;
         exp_q.push_back({1'b1, cw});
      end
   endtask

   // compare one accepted output word with the queue front
   task automatic check_output();
      logic [ilk_pkg::WORD_W:0] exp;
      assert (exp_q.size() != 0) else begin
         other_count++;
         $display("%0t: output word appeared with nothing expected", $time);
      end
      if (exp_q.size() != 0) begin
         exp = exp_q.pop_front();
         assert (tx_ctrl == exp[64]) else begin
            mismatch_count++;
            $display("mismatch at %0t: tx_ctrl expected %b actual %b", $time, exp[64], tx_ctrl);
         end
         assert (tx_data == exp[63:0]) else begin
            mismatch_count++;
            $display("mismatch at %0t: tx_data expected %h actual %h",
                     $time, exp[63:0], tx_data);
         end
      end
   endtask

   // falling edge monitor for handshakes that complete on the next rising edge
   always @(negedge clk) begin
      if (!arst_n) begin
         assert (!tx_valid) else begin
            other_count++;
            $display("%0t: tx_valid high during reset", $time);
         end
      end else if (post_reset_cycles < 2) begin
         post_reset_cycles++;
         assert (!tx_valid) else begin
            other_count++;
            $display("%0t: tx_valid high right after reset", $time);
         end
      end
      if (arst_n && avl_valid && avl_ready) predict_beat();
      if (arst_n && tx_valid && tx_ready) check_output();
   end

   // starts on a rising edge and returns on the edge that takes the beat
   task automatic send_beat(input logic [127:0] data, input logic sop, input logic eop,
                            input logic [3:0] empty, input logic err, input logic [7:0] chan);
      int waited;
      avl_data    <= data;
      avl_sop     <= sop;
      avl_eop     <= eop;
      avl_empty   <= empty;
      avl_error   <= err;
      avl_channel <= chan;
      avl_valid   <= 1'b1;
      waited = 0;
      @(negedge clk);
      while (!avl_ready && waited < BEAT_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      assert (avl_ready) else begin
         other_count++;
         timed_out = 1'b1;
         $display("%0t: avalon beat was never accepted", $time);
      end
      @(posedge clk);
   endtask

   task automatic send_packet();
      logic [31:0]  r;
      int           n_beats;
      logic [7:0]   chan;
      logic         err;
      logic [127:0] data;
      logic [3:0]   empty;
      r       = next_rand();
      n_beats = 1 + (r[31:16] % 6);
      chan    = r[15:8];
      r       = next_rand();
      // error on roughly one packet in eight
      err     = (r[31:29] == 3'b000);
      for (int b = 0; b < n_beats && !timed_out; b++) begin
         for (int k = 0; k < 4; k++) data[k*32 +: 32] = next_rand();
         r = next_rand();
         if (b == n_beats - 1) begin
            empty = r[31:28];
         end else if (b == 0) begin
            empty = 4'd0;
         end else if (r[31:29] <= 3'd4) begin
            empty = 4'd0;
         end else if (r[31:29] == 3'd5) begin
            empty = 4'd8;
         end else begin
            // odd values only so never 0 or 8
            empty = r[23:20] | 4'b0001;
         end
         // idle gap now and then
         if (r[27:26] == 2'b00) begin
            avl_valid <= 1'b0;
            @(posedge clk);
         end
         send_beat(data, b == 0, b == n_beats - 1, empty, err, chan);
      end
   endtask

   initial begin
      int waited;
      arst_n            = 1'b0;
      avl_data          = '0;
      avl_sop           = 1'b0;
      avl_eop           = 1'b0;
      avl_empty         = '0;
      avl_error         = 1'b0;
      avl_valid         = 1'b0;
      avl_channel       = '0;
      tx_ready          = 1'b0;
      stim_state        = SEED;
      rdy_state         = SEED ^ 32'h9e37_79b9;
      mismatch_count    = 0;
      other_count       = 0;
      post_reset_cycles = 0;
      timed_out         = 1'b0;
      repeat (16) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);
      for (int p = 0; p < NUM_PKTS && !timed_out; p++) send_packet();
      avl_valid <= 1'b0;
      // let the pipeline drain
      waited = 0;
      while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
         @(posedge clk);
         waited++;
      end
      assert (exp_q.size() == 0) else begin
         other_count++;
         $display("%0t: %0d expected words never came out", $time, exp_q.size());
      end
      // catch stray words after the last expected one
      repeat (20) @(posedge clk);
      $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
      if (mismatch_count == 0 && other_count == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== all.f ====
ilk_pkg.sv
avl_to_ilk_adapter.sv
ilk_word_serializer.sv
ilk_ctrl_word_inserter.sv
ilk_tx_subsystem.sv
tb_ilk_tx.sv

// ==== Bender.yml ====
package:
  name: ilk_tx

sources:
  - ilk_pkg.sv
  - avl_to_ilk_adapter.sv
  - ilk_word_serializer.sv
  - ilk_ctrl_word_inserter.sv
  - ilk_tx_subsystem.sv
  - target: test
    files:
      - tb_ilk_tx.sv
